//--- vlog.f
+incdir+testbench
common/seq_state_pkg.sv
common/seq_timing_pkg.sv
source/sys_tick_gen.sv
source/button_press_detect.sv
reset_seq/reset_sequencer.sv
cpu_seq/cpu_sequencer.sv
source/board_reset_top.sv
testbench/tb_board_reset.sv

//--- run_sim.sh
#!/bin/sh
# Builds the board reset testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_board_reset -o tb_board_reset
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/tb_board_reset > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^NO ERRORS$" sim.log; then
   exit 0
else
   echo "simulation reported failures, see sim.log"
   exit 1
fi

//--- testbench/tb_board_reset_cases.svh
// Case table for the board reset testbench with stimulus and expected results.
`ifndef TB_BOARD_RESET_CASES_SVH
`define TB_BOARD_RESET_CASES_SVH

// a hold of zero slow ticks leaves the button untouched.
typedef struct {
   string        name;
   int unsigned  calib_med;   // calibration delay in medium ticks.
   int unsigned  hold_slow;   // button hold in slow ticks.
   int unsigned  exp_boots;   // boot pulses over the whole case.
   reset_state_t exp_rst;
   cpu_state_t   exp_cpu;
} case_t;

localparam int unsigned num_cases = 5;

case_t cases [num_cases];

function automatic case_t make_case(input string name, input int unsigned calib_med,
                                    input int unsigned hold_slow,
                                    input int unsigned exp_boots,
                                    input reset_state_t exp_rst,
                                    input cpu_state_t exp_cpu);
   case_t c;
   c.name      = name;
   c.calib_med = calib_med;
   c.hold_slow = hold_slow;
   c.exp_boots = exp_boots;
   c.exp_rst   = exp_rst;
   c.exp_cpu   = exp_cpu;
   return c;
endfunction

function automatic void fill_cases();
   cases[0] = make_case("quick_calib", 2, 0, 1, r_idle, c_idle);
   cases[1] = make_case("slow_calib", 24, 0, 1, r_idle, c_idle);
   cases[2] = make_case("long_press", 4, 12, 2, r_idle, c_idle);
   cases[3] = make_case("press_just_long", 3, press_ticks + 1, 2, r_idle, c_idle);
   cases[4] = make_case("short_press", 4, 5, 1, r_idle, c_idle);  // below the debounce window.
endfunction

`endif

//--- testbench/tb_board_reset.sv
// Testbench for the board reset sequencer covering calibration, boot and button presses.
`timescale 1ns/1ps

module tb_board_reset;
   import seq_state_pkg::*;
   import seq_timing_pkg::*;

   `include "tb_board_reset_cases.svh"

   localparam int unsigned reset_cycles = 10;

   logic         sysclk;
   logic         cpu_clk;
   logic         dcm_reset;
   logic         button_r;
   logic         lpddr_calib_done;
   logic         boot;
   logic         reset;
   logic         lpddr_reset;
   cpu_state_t   cpu_st;
   reset_state_t rst_st;

   int unsigned boot_edges  = 0;
   int unsigned reset_rises = 0;
   int unsigned error_count = 0;
   int unsigned pass_count  = 0;
   int unsigned fail_count  = 0;

   board_reset_top dut (
      .sysclk           (sysclk),
      .cpu_clk          (cpu_clk),
      .dcm_reset        (dcm_reset),
      .button_r         (button_r),
      .lpddr_calib_done (lpddr_calib_done),
      .boot             (boot),
      .reset            (reset),
      .lpddr_reset      (lpddr_reset),
      .cpu_st           (cpu_st),
      .rst_st           (rst_st)
   );

   ////////////////////////////////////////////////////////////////////////////
   // clocks and edge monitors

   always #2 sysclk = ~sysclk;

   // cpu_clk edges land on half ns points, away from the sampling instants.
   initial begin
      cpu_clk = 1'b0;
      #0.5;
      forever #3 cpu_clk = ~cpu_clk;
   end

   always @(posedge boot) boot_edges = boot_edges + 1;
   always @(posedge reset) reset_rises = reset_rises + 1;

   ////////////////////////////////////////////////////////////////////////////
   // checks and waits

   task automatic check_value(input string name, input string what,
                              input int unsigned expected, input int unsigned actual);
      if (expected != actual) begin
         $display("** Error %s: %s expected %0d, actual %0d", name, what, expected, actual);
         error_count = error_count + 1;
      end
   endtask

   function automatic bit idle_reached();
      return (cpu_st == c_idle) && (rst_st == r_idle) && !reset;
   endfunction

   task automatic wait_rst_state(input string name, input reset_state_t target,
                                 input int unsigned limit);
      int unsigned waited;
      waited = 0;
      while ((rst_st != target) && (waited < limit)) begin
         @(posedge sysclk);
         #1;
         waited = waited + 1;
      end
      if (rst_st != target) begin
         $display("case %s: rst_st did not reach %s within %0d cycles", name,
                  target.name(), limit);
         error_count = error_count + 1;
      end
   endtask

   task automatic wait_idle(input string name, input int unsigned limit);
      int unsigned waited;
      waited = 0;
      while (!idle_reached() && (waited < limit)) begin
         @(posedge sysclk);
         #1;
         waited = waited + 1;
      end
      if (!idle_reached()) begin
         $display("case %s: both sequencers did not settle in idle within %0d cycles",
                  name, limit);
         error_count = error_count + 1;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // one case of the table

   task automatic run_case(input case_t tc);
      int unsigned errors_before;
      int unsigned boots_before;
      int unsigned rises_before;
      int unsigned calib_wait;
      errors_before = error_count;

      @(posedge sysclk);
      #1;
      dcm_reset        = 1'b1;
      button_r         = 1'b0;
      lpddr_calib_done = 1'b0;
      repeat (reset_cycles) @(posedge sysclk);
      #1;
      dcm_reset    = 1'b0;
      boots_before = boot_edges;
      check_value(tc.name, "reset after dcm_reset", 1, reset);
      check_value(tc.name, "boot after dcm_reset", 0, boot);
      check_value(tc.name, "lpddr_reset after dcm_reset", 0, lpddr_reset);

      // memory reset comes up once the holdoff has run out.
      repeat (holdoff_cycles + 1) @(posedge sysclk);
      #1;
      check_value(tc.name, "rst_st after holdoff", int'(r_init), int'(rst_st));
      check_value(tc.name, "lpddr_reset after holdoff", 1, lpddr_reset);

      wait_rst_state(tc.name, r_reset3, 8 * med_period);
      calib_wait = tc.calib_med + $urandom_range(3, 0);
      repeat (calib_wait * med_period) @(posedge sysclk);
      #1;
      check_value(tc.name, "rst_st without calibration", int'(r_reset3), int'(rst_st));
      check_value(tc.name, "reset without calibration", 1, reset);
      check_value(tc.name, "boot pulses without calibration", 0, boot_edges - boots_before);

      lpddr_calib_done = 1'b1;
      wait_idle(tc.name, 16 * med_period);
      check_value(tc.name, "boot pulses after calibration", 1, boot_edges - boots_before);

      if (tc.hold_slow > 0) begin
         rises_before = reset_rises;
         button_r     = 1'b1;
         repeat (tc.hold_slow * slow_period) @(posedge sysclk);
         #1;
         button_r = 1'b0;
         // the press window only moves on slow ticks.
         repeat (2 * slow_period) @(posedge sysclk);
         #1;
         wait_idle(tc.name, 16 * med_period);
         check_value(tc.name, "reset raised by the press", tc.hold_slow >= press_ticks,
                     reset_rises != rises_before);
      end

      check_value(tc.name, "final rst_st", int'(tc.exp_rst), int'(rst_st));
      check_value(tc.name, "final cpu_st", int'(tc.exp_cpu), int'(cpu_st));
      check_value(tc.name, "boot pulses", tc.exp_boots, boot_edges - boots_before);
      check_value(tc.name, "final reset", 0, reset);

      if (error_count == errors_before) begin
         pass_count = pass_count + 1;
         $display("case %s passed", tc.name);
      end else begin
         fail_count = fail_count + 1;
         $display("case %s failed with %0d mismatches", tc.name, error_count - errors_before);
      end
   endtask

   // worst case length of the whole table in sysclk cycles, with a margin of two.
   function automatic longint unsigned run_budget();
      longint unsigned total;
      total = 0;
      for (int i = 0; i < num_cases; i++) begin
         total += reset_cycles + holdoff_cycles + 4;
         total += (cases[i].calib_med + 3 + 8 + 32) * med_period;
         total += (cases[i].hold_slow + press_ticks + 2) * slow_period;
      end
      return 2 * total;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // main sequence and watchdog

   initial begin
      sysclk           = 1'b0;
      dcm_reset        = 1'b1;
      button_r         = 1'b0;
      lpddr_calib_done = 1'b0;
      void'($urandom(32'h3377_ca8b));
      fill_cases();
      for (int i = 0; i < num_cases; i++) begin
         run_case(cases[i]);
      end
      $display("%0d cases run, %0d passed, %0d failed, %0d check errors",
               num_cases, pass_count, fail_count, error_count);
      if (error_count == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   initial begin
      longint unsigned budget;
      @(posedge sysclk);  // the table is filled at time zero.
      budget = run_budget();
      repeat (budget) @(posedge sysclk);
      $display("watchdog expired after %0d sysclk cycles before the cases completed", budget);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

//--- source/board_reset_top.sv
// Board reset and boot sequencer spanning the system and CPU clock domains.
`timescale 1ns/1ps

module board_reset_top (
   input  logic                        sysclk,
   input  logic                        cpu_clk,
   input  logic                        dcm_reset,
   input  logic                        button_r,
   input  logic                        lpddr_calib_done,
   output logic                        boot,
   output logic                        reset,
   output logic                        lpddr_reset,
   output seq_state_pkg::cpu_state_t   cpu_st,
   output seq_state_pkg::reset_state_t rst_st
);
   import seq_state_pkg::*;

   logic        med_tick;
   logic        slow_tick;
   logic        holdoff_done;
   logic        pressed;
   logic        sys_in_reset;
   sys_to_cpu_t sys_flags;
   cpu_to_sys_t cpu_flags;

   ////////////////////////////////////////////////////////////////////////////
   // system domain

   sys_tick_gen u_tick (
      .sysclk       (sysclk),
      .dcm_reset    (dcm_reset),
      .med_tick     (med_tick),
      .slow_tick    (slow_tick),
      .holdoff_done (holdoff_done)
   );

   button_press_detect u_press (
      .sysclk    (sysclk),
      .dcm_reset (dcm_reset),
      .button_r  (button_r),
      .slow_tick (slow_tick),
      .pressed   (pressed)
   );

   reset_sequencer u_rst_seq (
      .sysclk           (sysclk),
      .dcm_reset        (dcm_reset),
      .med_tick         (med_tick),
      .pressed          (pressed),
      .holdoff_done     (holdoff_done),
      .lpddr_calib_done (lpddr_calib_done),
      .cpu_flags        (cpu_flags),
      .sys_flags        (sys_flags),
      .lpddr_reset      (lpddr_reset),
      .sys_in_reset     (sys_in_reset),
      .rst_st           (rst_st)
   );

   ////////////////////////////////////////////////////////////////////////////
   // CPU domain

   cpu_sequencer u_cpu_seq (
      .cpu_clk   (cpu_clk),
      .dcm_reset (dcm_reset),
      .sys_flags (sys_flags),
      .cpu_flags (cpu_flags),
      .boot      (boot),
      .cpu_st    (cpu_st)
   );

   // the CPU side asserts reset at once. release waits for the sysclk view.
   assign reset = sys_in_reset || cpu_flags.cpu_in_reset;

endmodule

//--- cpu_seq/cpu_sequencer.sv
// CPU domain reset and boot phase sequencer, paced by a four-cycle prescaler.
`timescale 1ns/1ps

module cpu_sequencer (
   input  logic                       cpu_clk,
   input  logic                       dcm_reset,
   input  seq_state_pkg::sys_to_cpu_t sys_flags,
   output seq_state_pkg::cpu_to_sys_t cpu_flags,
   output logic                       boot,
   output seq_state_pkg::cpu_state_t  cpu_st
);
   import seq_state_pkg::*;

   sys_to_cpu_t sys_meta;
   sys_to_cpu_t sys_sync;
   logic [1:0]  presc_q;
   logic        step;
   logic        start_seen;
   cpu_state_t  state_q;
   cpu_state_t  state_next;
   cpu_to_sys_t flags_q;

   function automatic cpu_to_sys_t flags_for(input cpu_state_t st);
      cpu_to_sys_t f;
      f.cpu_idle     = (st == c_idle);
      f.cpu_in_reset = (st == c_init) || (st == c_reset1) ||
                       (st == c_reset2) || (st == c_reset3);
      return f;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // synchronizer and prescaler

   always_ff @(posedge cpu_clk or posedge dcm_reset) begin
      if (dcm_reset) begin
         sys_meta <= '{start_cpu: 1'b0, sys_idle: 1'b0, sys_in_reset: 1'b1};
         sys_sync <= '{start_cpu: 1'b0, sys_idle: 1'b0, sys_in_reset: 1'b1};
         presc_q  <= 2'd0;
      end else begin
         sys_meta <= sys_flags;
         sys_sync <= sys_meta;
         presc_q  <= presc_q + 2'd1;
      end
   end

   assign step = (presc_q == 2'b11);

   // the bits may cross one cycle apart. start only once both agree.
   assign start_seen = sys_sync.start_cpu && !sys_sync.sys_in_reset;

   ////////////////////////////////////////////////////////////////////////////
   // phase FSM

   always_comb begin
      state_next = state_q;
      case (state_q)
         c_init,
         c_idle:   if (start_seen) state_next = c_reset1;
         c_reset1: state_next = c_reset2;
         c_reset2: state_next = c_reset3;
         c_reset3: state_next = c_boot;
         c_boot:   state_next = c_wait;
         c_wait:   if (sys_sync.sys_idle) state_next = c_idle;
         default:  state_next = c_init;
      endcase
   end

   always_ff @(posedge cpu_clk or posedge dcm_reset) begin
      if (dcm_reset) begin
         state_q <= c_init;
         flags_q <= '{cpu_idle: 1'b0, cpu_in_reset: 1'b1};
      end else if (step) begin
         state_q <= state_next;
         flags_q <= flags_for(state_next);
      end
   end

   assign boot      = (state_q == c_reset3) || (state_q == c_boot);  // two step strobe.
   assign cpu_flags = flags_q;
   assign cpu_st    = state_q;

endmodule

//--- reset_seq/reset_sequencer.sv
// System domain reset phase sequencer that gates memory reset and starts the CPU.
`timescale 1ns/1ps

module reset_sequencer (
   input  logic                        sysclk,
   input  logic                        dcm_reset,
   input  logic                        med_tick,
   input  logic                        pressed,
   input  logic                        holdoff_done,
   input  logic                        lpddr_calib_done,
   input  seq_state_pkg::cpu_to_sys_t  cpu_flags,
   output seq_state_pkg::sys_to_cpu_t  sys_flags,
   output logic                        lpddr_reset,
   output logic                        sys_in_reset,
   output seq_state_pkg::reset_state_t rst_st
);
   import seq_state_pkg::*;

   logic         calib_meta;
   logic         calib_sync;
   cpu_to_sys_t  cpu_meta;
   cpu_to_sys_t  cpu_sync;
   reset_state_t state_q;
   reset_state_t state_next;
   sys_to_cpu_t  flags_q;

   // flag decode for a given phase.
   function automatic sys_to_cpu_t flags_for(input reset_state_t st);
      sys_to_cpu_t f;
      f.start_cpu    = (st == r_reset4);
      f.sys_idle     = (st == r_idle);
      f.sys_in_reset = (st == r_init) || (st == r_reset1) ||
                       (st == r_reset2) || (st == r_reset3);
      return f;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // synchronizers into sysclk

   always_ff @(posedge sysclk or posedge dcm_reset) begin
      if (dcm_reset) begin
         calib_meta <= 1'b0;
         calib_sync <= 1'b0;
         cpu_meta   <= '{cpu_idle: 1'b0, cpu_in_reset: 1'b1};
         cpu_sync   <= '{cpu_idle: 1'b0, cpu_in_reset: 1'b1};
      end else begin
         calib_meta <= lpddr_calib_done;
         calib_sync <= calib_meta;
         cpu_meta   <= cpu_flags;
         cpu_sync   <= cpu_meta;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // phase FSM

   always_comb begin
      state_next = state_q;
      case (state_q)
         r_init:   state_next = r_reset1;
         r_reset1: state_next = r_reset2;
         r_reset2: state_next = r_reset3;
         r_reset3: if (calib_sync) state_next = r_reset4;
         r_reset4: if (!cpu_sync.cpu_idle) state_next = r_wait;  // CPU has left idle.
         r_wait:   if (!pressed) state_next = r_idle;
         r_idle:   if (pressed) state_next = r_reset1;
         default:  state_next = r_init;  // r_reset5 is never entered.
      endcase
   end

   // flags are registered with the phase so the other domain sees clean bits.
   always_ff @(posedge sysclk or posedge dcm_reset) begin
      if (dcm_reset) begin
         state_q <= r_init;
         flags_q <= '{start_cpu: 1'b0, sys_idle: 1'b0, sys_in_reset: 1'b1};
      end else if (med_tick) begin
         state_q <= state_next;
         flags_q <= flags_for(state_next);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // outputs

   assign lpddr_reset  = ((state_q == r_init) || (state_q == r_reset1)) && holdoff_done;
   assign sys_in_reset = flags_q.sys_in_reset || cpu_sync.cpu_in_reset;
   assign sys_flags    = flags_q;
   assign rst_st       = state_q;

endmodule

//--- source/button_press_detect.sv
// Debounces the reset button on slow ticks and flags a sustained press once.
`timescale 1ns/1ps

module button_press_detect (
   input  logic sysclk,
   input  logic dcm_reset,
   input  logic button_r,
   input  logic slow_tick,
   output logic pressed
);
   import seq_timing_pkg::*;

   hold_shift_t hist_q;
   logic        was_held_q;
   logic        held;

   // the button counts as held once every sample in the window is high.
   assign held = &hist_q;

   always_ff @(posedge sysclk or posedge dcm_reset) begin
      if (dcm_reset) begin
         hist_q     <= '0;
         was_held_q <= 1'b0;
      end else if (slow_tick) begin
         hist_q     <= {hist_q[press_ticks-2:0], button_r};
         was_held_q <= held;  // state of the window one tick back.
      end
   end

   // high for the first slow tick interval of a hold, never again until release.
   assign pressed = held && !was_held_q;

endmodule

//--- source/sys_tick_gen.sv
// Medium and slow tick dividers on sysclk plus the memory reset holdoff counter.
`timescale 1ns/1ps

module sys_tick_gen (
   input  logic sysclk,
   input  logic dcm_reset,
   output logic med_tick,
   output logic slow_tick,
   output logic holdoff_done
);
   import seq_timing_pkg::*;

   med_count_t     med_cnt;
   slow_count_t    slow_cnt;
   holdoff_count_t holdoff_cnt;

   ////////////////////////////////////////////////////////////////////////////
   // free-running dividers

   always_ff @(posedge sysclk or posedge dcm_reset) begin
      if (dcm_reset) begin
         med_cnt  <= '0;
         slow_cnt <= '0;
      end else begin
         med_cnt  <= med_cnt + 1'b1;   // both wrap at their period.
         slow_cnt <= slow_cnt + 1'b1;
      end
   end

   assign med_tick  = (med_cnt == med_count_t'(med_period - 1));
   assign slow_tick = (slow_cnt == slow_count_t'(slow_period - 1));

   ////////////////////////////////////////////////////////////////////////////
   // memory reset holdoff

   // counts once after reset and then sticks at the terminal value.
   always_ff @(posedge sysclk or posedge dcm_reset) begin
      if (dcm_reset) begin
         holdoff_cnt <= '0;
      end else if (!holdoff_done) begin
         holdoff_cnt <= holdoff_cnt + 1'b1;
      end
   end

   assign holdoff_done = (holdoff_cnt == holdoff_count_t'(holdoff_cycles));

endmodule

//--- common/seq_timing_pkg.sv
// Divider periods, holdoff and press lengths of the board reset logic.
package seq_timing_pkg;

   // terminal values, in sysclk cycles or slow ticks.
   localparam int unsigned med_period     = 64;
   localparam int unsigned slow_period    = 4096;
   localparam int unsigned holdoff_cycles = 15;
   localparam int unsigned press_ticks    = 10;  // slow ticks of a held button.

   // counter widths follow from the terminal values above.
   typedef logic [$clog2(med_period)-1:0]       med_count_t;
   typedef logic [$clog2(slow_period)-1:0]      slow_count_t;
   typedef logic [$clog2(holdoff_cycles+1)-1:0] holdoff_count_t;

   // one bit per slow tick sample of the button.
   typedef logic [press_ticks-1:0] hold_shift_t;

endpackage

//--- common/seq_state_pkg.sv
// Phase encodings of the reset and boot sequencers and the flags they exchange.
package seq_state_pkg;

   typedef logic [2:0] seq_state_vec_t;

   ////////////////////////////////////////////////////////////////////////////
   // phase encodings

   // system domain phases, stepped on the medium tick.
   typedef enum seq_state_vec_t {
      r_init   = 3'd0,
      r_reset1 = 3'd1,
      r_reset2 = 3'd2,
      r_reset3 = 3'd3,
      r_reset4 = 3'd4,
      r_reset5 = 3'd5,
      r_wait   = 3'd6,
      r_idle   = 3'd7
   } reset_state_t;

   typedef enum seq_state_vec_t {
      c_init   = 3'd0,
      c_reset1 = 3'd1,
      c_reset2 = 3'd2,
      c_reset3 = 3'd3,
      c_boot   = 3'd4,
      c_wait   = 3'd5,
      c_idle   = 3'd6
   } cpu_state_t;

   ////////////////////////////////////////////////////////////////////////////
   // cross-domain status

   typedef struct packed {
      logic start_cpu;     // system side sits in r_reset4.
      logic sys_idle;
      logic sys_in_reset;  // r_init through r_reset3.
   } sys_to_cpu_t;

   typedef struct packed {
      logic cpu_idle;
      logic cpu_in_reset;  // c_init through c_reset3.
   } cpu_to_sys_t;

endpackage
